/* verilog/exu_pkg.sv */
package exu_pkg;

  // datapath width
  localparam int xlen = 64;

  // machine csr addresses
  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  // mstatus bit positions
  localparam int mstatus_mie  = 3;
  localparam int mstatus_mpie = 7;

  // environment call from machine mode
  localparam logic [xlen-1:0] cause_ecall_m = 64'd11;

  typedef enum logic [3:0] {
    cls_alu,
    cls_load,
    cls_store,
    cls_branch,
    cls_jal,
    cls_jalr,
    cls_csr,
    cls_ecall,
    cls_mret,
    cls_ebreak
  } op_class_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_sge,
    alu_sgeu
  } alu_op_e;

  typedef enum logic [1:0] {
    csr_rw,
    csr_rs,
    csr_rc
  } csr_op_e;

endpackage

/* verilog/exu_alu.sv */
`timescale 1ns/1ps

module exu_alu (
  input  exu_pkg::alu_op_e         op_i,
  input  logic [exu_pkg::xlen-1:0] a_i,
  input  logic [exu_pkg::xlen-1:0] b_i,
  output logic [exu_pkg::xlen-1:0] res_o
);
  import exu_pkg::*;

  logic [5:0] shamt;
  logic       lt_s;
  logic       lt_u;

  // rv64 shifts only look at six bits
  assign shamt = b_i[5:0];

  assign lt_s = $signed(a_i) < $signed(b_i);
  assign lt_u = a_i < b_i;

  always_comb begin
    case (op_i)
      alu_add: begin
        res_o = a_i + b_i;
      end
      alu_sub: begin
        res_o = a_i - b_i;
      end
      alu_and: begin
        res_o = a_i & b_i;
      end
      alu_or: begin
        res_o = a_i | b_i;
      end
      alu_xor: begin
        res_o = a_i ^ b_i;
      end
      alu_sll: begin
        res_o = a_i << shamt;
      end
      alu_srl: begin
        res_o = a_i >> shamt;
      end
      alu_sra: begin
        res_o = $unsigned($signed(a_i) >>> shamt);
      end
      // compares give 0 or 1 for the branch test on nonzero
      alu_slt: res_o = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu: res_o = {{(xlen-1){1'b0}}, lt_u};
      alu_sge: res_o = {{(xlen-1){1'b0}}, ~lt_s};
      alu_sgeu: res_o = {{(xlen-1){1'b0}}, ~lt_u};
      default: res_o = '0;
    endcase
  end

endmodule

/* verilog/exu_csr_file.sv */
`timescale 1ns/1ps

module exu_csr_file (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [11:0]              addr_i,
  output logic [exu_pkg::xlen-1:0] rdata_o,
  input  logic                     wen_i,
  input  logic [exu_pkg::xlen-1:0] wdata_i,
  input  logic                     trap_i,
  input  logic [exu_pkg::xlen-1:0] trap_pc_i,
  input  logic                     mret_i,
  output logic [exu_pkg::xlen-1:0] mtvec_o,
  output logic [exu_pkg::xlen-1:0] mepc_o
);
  import exu_pkg::*;

  logic [xlen-1:0] mstatus_q;
  logic [xlen-1:0] mtvec_q;
  logic [xlen-1:0] mepc_q;
  logic [xlen-1:0] mcause_q;

  // unknown addresses read as zero
  always_comb begin
    case (addr_i)
      csr_mstatus: rdata_o = mstatus_q;
      csr_mtvec:   rdata_o = mtvec_q;
      csr_mepc:    rdata_o = mepc_q;
      csr_mcause:  rdata_o = mcause_q;
      default:     rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      if (wen_i) begin
        case (addr_i)
          csr_mstatus: mstatus_q <= wdata_i;
          csr_mtvec:   mtvec_q   <= wdata_i;
          csr_mepc:    mepc_q    <= wdata_i;
          csr_mcause:  mcause_q  <= wdata_i;
          default: ;
        endcase
      end
      // only ecall traps here
      if (trap_i) begin
        mepc_q   <= trap_pc_i;
        mcause_q <= cause_ecall_m;
      end
      if (mret_i) begin
        mstatus_q[mstatus_mie]  <= mstatus_q[mstatus_mpie];
        mstatus_q[mstatus_mpie] <= 1'b1;
      end
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

endmodule

/* verilog/exu_stage.sv */
`timescale 1ns/1ps

module exu_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     valid_i,
  output logic                     ready_o,
  input  exu_pkg::op_class_e       class_i,
  input  exu_pkg::alu_op_e         alu_op_i,
  input  exu_pkg::csr_op_e         csr_op_i,
  input  logic [11:0]              csr_addr_i,
  input  logic [exu_pkg::xlen-1:0] src1_i,
  input  logic [exu_pkg::xlen-1:0] src2_i,
  input  logic [exu_pkg::xlen-1:0] base_i,
  input  logic [exu_pkg::xlen-1:0] imm_i,
  input  logic [exu_pkg::xlen-1:0] pc_i,
  input  logic [4:0]               rd_i,
  input  logic                     rd_wen_i,
  output logic                     s1_valid_o,
  output exu_pkg::op_class_e       s1_class_o,
  output logic [4:0]               s1_rd_o,
  output logic                     s1_wen_o,
  output logic [exu_pkg::xlen-1:0] s1_result_o,
  output logic                     s1_redirect_o,
  output logic [exu_pkg::xlen-1:0] s1_redirect_pc_o,
  output logic                     s1_ebreak_o,
  output logic [exu_pkg::xlen-1:0] s1_mem_addr_o,
  output logic [exu_pkg::xlen-1:0] s1_mem_wdata_o,
  input  logic                     s2_ready_i
);
  import exu_pkg::*;

  logic            valid_q;
  op_class_e       class_q;
  alu_op_e         alu_op_q;
  csr_op_e         csr_op_q;
  logic [11:0]     csr_addr_q;
  logic [xlen-1:0] src1_q;
  logic [xlen-1:0] src2_q;
  logic [xlen-1:0] base_q;
  logic [xlen-1:0] imm_q;
  logic [xlen-1:0] pc_q;
  logic [4:0]      rd_q;
  logic            rd_wen_q;

  logic            handoff;
  logic            taken;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] target;
  logic [11:0]     csr_raddr;
  logic [xlen-1:0] csr_rdata;
  logic [xlen-1:0] csr_wdata;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;

  assign handoff = valid_q && s2_ready_i;
  assign ready_o = !valid_q || s2_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      class_q    <= class_i;
      alu_op_q   <= alu_op_i;
      csr_op_q   <= csr_op_i;
      csr_addr_q <= csr_addr_i;
      src1_q     <= src1_i;
      src2_q     <= src2_i;
      base_q     <= base_i;
      imm_q      <= imm_i;
      pc_q       <= pc_i;
      rd_q       <= rd_i;
      rd_wen_q   <= rd_wen_i;
    end
  end

  exu_alu u_alu (
    .op_i  (alu_op_q),
    .a_i   (src1_q),
    .b_i   (src2_q),
    .res_o (alu_res)
  );

  // mret reads mstatus as its result
  assign csr_raddr = (class_q == cls_mret) ? csr_mstatus : csr_addr_q;

  always_comb begin
    case (csr_op_q)
      csr_rs:  csr_wdata = csr_rdata | src1_q;
      csr_rc:  csr_wdata = csr_rdata & ~src1_q;
      default: csr_wdata = src1_q;
    endcase
  end

  // side effects land once, as the instruction leaves
  exu_csr_file u_csr_file (
    .clk       (clk),
    .rst       (rst),
    .addr_i    (csr_raddr),
    .rdata_o   (csr_rdata),
    .wen_i     (handoff && class_q == cls_csr),
    .wdata_i   (csr_wdata),
    .trap_i    (handoff && class_q == cls_ecall),
    .trap_pc_i (pc_q),
    .mret_i    (handoff && class_q == cls_mret),
    .mtvec_o   (mtvec),
    .mepc_o    (mepc)
  );

  assign target = base_q + imm_q;

  always_comb begin
    case (alu_op_q)
      alu_sub: taken = alu_res == '0;
      alu_xor, alu_slt, alu_sltu, alu_sge, alu_sgeu: taken = alu_res != '0;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    s1_result_o      = '0;
    s1_redirect_o    = 1'b0;
    s1_redirect_pc_o = target;
    s1_ebreak_o      = 1'b0;
    case (class_q)
      cls_alu: s1_result_o = alu_res;
      cls_branch: s1_redirect_o = taken;
      cls_jal, cls_jalr: begin
        s1_result_o   = pc_q + 64'd4;
        s1_redirect_o = 1'b1;
      end
      cls_csr: s1_result_o = csr_rdata;
      cls_ecall: begin
        s1_redirect_o    = 1'b1;
        s1_redirect_pc_o = mtvec;
      end
      cls_mret: begin
        s1_result_o      = csr_rdata;
        s1_redirect_o    = 1'b1;
        s1_redirect_pc_o = mepc;
      end
      cls_ebreak: begin
        s1_redirect_o    = 1'b1;
        s1_redirect_pc_o = pc_q;
        s1_ebreak_o      = 1'b1;
      end
      default: ;
    endcase
  end

  assign s1_valid_o     = valid_q;
  assign s1_class_o     = class_q;
  assign s1_rd_o        = rd_q;
  assign s1_wen_o       = rd_wen_q && class_q != cls_branch && class_q != cls_store;
  assign s1_mem_addr_o  = target;
  assign s1_mem_wdata_o = src2_q;

endmodule

/* verilog/exu_mem_stage.sv */
`timescale 1ns/1ps

module exu_mem_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     s1_valid_i,
  input  exu_pkg::op_class_e       s1_class_i,
  input  logic [4:0]               s1_rd_i,
  input  logic                     s1_wen_i,
  input  logic [exu_pkg::xlen-1:0] s1_result_i,
  input  logic                     s1_redirect_i,
  input  logic [exu_pkg::xlen-1:0] s1_redirect_pc_i,
  input  logic                     s1_ebreak_i,
  input  logic [exu_pkg::xlen-1:0] s1_mem_addr_i,
  input  logic [exu_pkg::xlen-1:0] s1_mem_wdata_i,
  output logic                     s2_ready_o,
  input  logic                     ready_i,
  output logic                     valid_o,
  output logic [4:0]               wb_rd_o,
  output logic                     wb_wen_o,
  output logic [exu_pkg::xlen-1:0] wb_data_o,
  output logic                     redirect_o,
  output logic [exu_pkg::xlen-1:0] redirect_pc_o,
  output logic                     ebreak_o,
  output logic                     lsu_req_o,
  output logic                     lsu_we_o,
  output logic [exu_pkg::xlen-1:0] lsu_addr_o,
  output logic [exu_pkg::xlen-1:0] lsu_wdata_o,
  input  logic                     lsu_ack_i,
  input  logic [exu_pkg::xlen-1:0] lsu_rdata_i
);
  import exu_pkg::*;

  typedef enum logic [1:0] {
    st_empty,
    st_bus,
    st_done
  } state_e;

  state_e          state_q;
  op_class_e       class_q;
  logic [4:0]      rd_q;
  logic            wen_q;
  logic [xlen-1:0] result_q;
  logic            redirect_q;
  logic [xlen-1:0] redirect_pc_q;
  logic            ebreak_q;
  logic [xlen-1:0] addr_q;
  logic [xlen-1:0] wdata_q;
  logic            take;
  logic            is_mem;

  assign valid_o    = state_q == st_done;
  assign s2_ready_o = state_q == st_empty || (valid_o && ready_i);
  assign take       = s1_valid_i && s2_ready_o;
  assign is_mem     = s1_class_i == cls_load || s1_class_i == cls_store;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_empty;
    end else if (take) begin
      state_q <= is_mem ? st_bus : st_done;
    end else if (state_q == st_bus && lsu_ack_i) begin
      state_q <= st_done;
    end else if (valid_o && ready_i) begin
      state_q <= st_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      class_q       <= s1_class_i;
      rd_q          <= s1_rd_i;
      wen_q         <= s1_wen_i;
      result_q      <= s1_result_i;
      redirect_q    <= s1_redirect_i;
      redirect_pc_q <= s1_redirect_pc_i;
      ebreak_q      <= s1_ebreak_i;
      addr_q        <= s1_mem_addr_i;
      wdata_q       <= s1_mem_wdata_i;
    end else if (state_q == st_bus && lsu_ack_i && class_q == cls_load) begin
      // read data becomes the result
      result_q <= lsu_rdata_i;
    end
  end

  // request held until the ack edge
  assign lsu_req_o   = state_q == st_bus;
  assign lsu_we_o    = class_q == cls_store;
  assign lsu_addr_o  = addr_q;
  assign lsu_wdata_o = wdata_q;

  assign wb_rd_o       = rd_q;
  assign wb_wen_o      = valid_o && wen_q;
  assign wb_data_o     = result_q;
  assign redirect_o    = valid_o && redirect_q;
  assign redirect_pc_o = redirect_pc_q;
  assign ebreak_o      = valid_o && ebreak_q;

endmodule

/* verilog/exu_top.sv */
`timescale 1ns/1ps

module exu_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     valid_i,
  output logic                     ready_o,
  input  exu_pkg::op_class_e       class_i,
  input  exu_pkg::alu_op_e         alu_op_i,
  input  exu_pkg::csr_op_e         csr_op_i,
  input  logic [11:0]              csr_addr_i,
  input  logic [exu_pkg::xlen-1:0] src1_i,
  input  logic [exu_pkg::xlen-1:0] src2_i,
  input  logic [exu_pkg::xlen-1:0] base_i,
  input  logic [exu_pkg::xlen-1:0] imm_i,
  input  logic [exu_pkg::xlen-1:0] pc_i,
  input  logic [4:0]               rd_i,
  input  logic                     rd_wen_i,
  output logic                     valid_o,
  input  logic                     ready_i,
  output logic [4:0]               wb_rd_o,
  output logic                     wb_wen_o,
  output logic [exu_pkg::xlen-1:0] wb_data_o,
  output logic                     redirect_o,
  output logic [exu_pkg::xlen-1:0] redirect_pc_o,
  output logic                     ebreak_o,
  output logic                     lsu_req_o,
  output logic                     lsu_we_o,
  output logic [exu_pkg::xlen-1:0] lsu_addr_o,
  output logic [exu_pkg::xlen-1:0] lsu_wdata_o,
  input  logic                     lsu_ack_i,
  input  logic [exu_pkg::xlen-1:0] lsu_rdata_i
);
  import exu_pkg::*;

  logic            s1_valid;
  op_class_e       s1_class;
  logic [4:0]      s1_rd;
  logic            s1_wen;
  logic [xlen-1:0] s1_result;
  logic            s1_redirect;
  logic [xlen-1:0] s1_redirect_pc;
  logic            s1_ebreak;
  logic [xlen-1:0] s1_mem_addr;
  logic [xlen-1:0] s1_mem_wdata;
  logic            s2_ready;

  exu_stage u_exu_stage (
    .clk              (clk),
    .rst              (rst),
    .valid_i          (valid_i),
    .ready_o          (ready_o),
    .class_i          (class_i),
    .alu_op_i         (alu_op_i),
    .csr_op_i         (csr_op_i),
    .csr_addr_i       (csr_addr_i),
    .src1_i           (src1_i),
    .src2_i           (src2_i),
    .base_i           (base_i),
    .imm_i            (imm_i),
    .pc_i             (pc_i),
    .rd_i             (rd_i),
    .rd_wen_i         (rd_wen_i),
    .s1_valid_o       (s1_valid),
    .s1_class_o       (s1_class),
    .s1_rd_o          (s1_rd),
    .s1_wen_o         (s1_wen),
    .s1_result_o      (s1_result),
    .s1_redirect_o    (s1_redirect),
    .s1_redirect_pc_o (s1_redirect_pc),
    .s1_ebreak_o      (s1_ebreak),
    .s1_mem_addr_o    (s1_mem_addr),
    .s1_mem_wdata_o   (s1_mem_wdata),
    .s2_ready_i       (s2_ready)
  );

  exu_mem_stage u_exu_mem_stage (
    .clk              (clk),
    .rst              (rst),
    .s1_valid_i       (s1_valid),
    .s1_class_i       (s1_class),
    .s1_rd_i          (s1_rd),
    .s1_wen_i         (s1_wen),
    .s1_result_i      (s1_result),
    .s1_redirect_i    (s1_redirect),
    .s1_redirect_pc_i (s1_redirect_pc),
    .s1_ebreak_i      (s1_ebreak),
    .s1_mem_addr_i    (s1_mem_addr),
    .s1_mem_wdata_i   (s1_mem_wdata),
    .s2_ready_o       (s2_ready),
    .ready_i          (ready_i),
    .valid_o          (valid_o),
    .wb_rd_o          (wb_rd_o),
    .wb_wen_o         (wb_wen_o),
    .wb_data_o        (wb_data_o),
    .redirect_o       (redirect_o),
    .redirect_pc_o    (redirect_pc_o),
    .ebreak_o         (ebreak_o),
    .lsu_req_o        (lsu_req_o),
    .lsu_we_o         (lsu_we_o),
    .lsu_addr_o       (lsu_addr_o),
    .lsu_wdata_o      (lsu_wdata_o),
    .lsu_ack_i        (lsu_ack_i),
    .lsu_rdata_i      (lsu_rdata_i)
  );

endmodule

/* tests/exu_sva.sv */
`timescale 1ns/1ps

module exu_sva (
  input logic        clk,
  input logic        rst,
  input logic        req_i,
  input logic        ack_i,
  input logic        we_i,
  input logic [63:0] addr_i,
  input logic [63:0] wdata_i,
  input logic        valid_i,
  input logic        ready_i,
  input logic [4:0]  rd_i,
  input logic        wen_i,
  input logic [63:0] data_i,
  input logic        redirect_i,
  input logic [63:0] redirect_pc_i,
  input logic        ebreak_i
);

  req_hold: assert property (@(posedge clk) disable iff (rst)
    req_i && !ack_i |=> req_i && $stable(addr_i) && $stable(wdata_i) && $stable(we_i))
    else $error("bus request dropped or changed before ack");

  out_hold: assert property (@(posedge clk) disable iff (rst)
    valid_i && !ready_i |=> valid_i && $stable(data_i) && $stable(wen_i) && $stable(rd_i)
      && $stable(redirect_i) && $stable(redirect_pc_i) && $stable(ebreak_i))
    else $error("retire outputs changed while stalled");

  reset_state: assert property (@(posedge clk) rst |=> !valid_i && !req_i)
    else $error("stage not empty after reset");

endmodule

bind exu_mem_stage exu_sva sva_i (
  .clk           (clk),
  .rst           (rst),
  .req_i         (lsu_req_o),
  .ack_i         (lsu_ack_i),
  .we_i          (lsu_we_o),
  .addr_i        (lsu_addr_o),
  .wdata_i       (lsu_wdata_o),
  .valid_i       (valid_o),
  .ready_i       (ready_i),
  .rd_i          (wb_rd_o),
  .wen_i         (wb_wen_o),
  .data_i        (wb_data_o),
  .redirect_i    (redirect_o),
  .redirect_pc_i (redirect_pc_o),
  .ebreak_i      (ebreak_o)
);

/* tests/exu_checker.sv */
`timescale 1ns/1ps

module exu_checker (
  input  logic        clk,
  input  logic        rst,
  input  logic        valid_i,
  input  logic        ready_i,
  input  logic [4:0]  wb_rd_i,
  input  logic        wb_wen_i,
  input  logic [63:0] wb_data_i,
  input  logic        redirect_i,
  input  logic [63:0] redirect_pc_i,
  input  logic        ebreak_i,
  input  logic        lsu_req_i,
  input  logic        lsu_ack_i,
  input  logic        lsu_we_i,
  input  logic [63:0] lsu_addr_i,
  input  logic [63:0] lsu_wdata_i,
  output int          errors_o,
  output int          retired_o,
  output int          pending_acc_o
);

  // expected retirements in order
  logic [63:0] e_data [$];
  logic [63:0] e_wen [$];
  logic [63:0] e_rd [$];
  logic [63:0] e_redir [$];
  logic [63:0] e_rpc [$];
  logic [63:0] e_ebreak [$];
  // expected bus accesses
  logic [63:0] e_we [$];
  logic [63:0] e_addr [$];
  logic [63:0] e_wdata [$];

  int error_count = 0;
  int next_res = 0;
  int next_acc = 0;
  int expected_acc = 0;

  assign errors_o      = error_count;
  assign retired_o     = next_res;
  assign pending_acc_o = expected_acc - next_acc;

  task expect_result(input logic [63:0] data, input logic [63:0] wen, input logic [63:0] rd,
                     input logic [63:0] redir, input logic [63:0] rpc,
                     input logic [63:0] ebreak);
    e_data.push_back(data);
    e_wen.push_back(wen);
    e_rd.push_back(rd);
    e_redir.push_back(redir);
    e_rpc.push_back(rpc);
    e_ebreak.push_back(ebreak);
  endtask

  task expect_access(input logic [63:0] we, input logic [63:0] addr, input logic [63:0] wdata);
    e_we.push_back(we);
    e_addr.push_back(addr);
    e_wdata.push_back(wdata);
    expected_acc++;
  endtask

  task automatic compare_field(input string name, input int idx, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: entry %0d %s got %h expected %h", $time, idx, name, got, exp);
      error_count++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      if (valid_i && ready_i) begin
        if (next_res >= e_data.size()) begin
          $display("an instruction retired at %0t with none left to expect", $time);
          error_count++;
        end else begin
          compare_field("wb_wen", next_res, 64'(wb_wen_i), e_wen[next_res]);
          compare_field("redirect", next_res, 64'(redirect_i), e_redir[next_res]);
          compare_field("ebreak", next_res, 64'(ebreak_i), e_ebreak[next_res]);
          if (e_wen[next_res] != 0) begin
            compare_field("wb_rd", next_res, 64'(wb_rd_i), e_rd[next_res]);
            compare_field("wb_data", next_res, wb_data_i, e_data[next_res]);
          end
          if (e_redir[next_res] != 0) begin
            compare_field("redirect_pc", next_res, redirect_pc_i, e_rpc[next_res]);
          end
          next_res++;
        end
      end
      // bus fields checked on the completing edge
      if (lsu_req_i && lsu_ack_i) begin
        if (next_acc >= e_addr.size()) begin
          $display("a bus access completed at %0t with none left to expect", $time);
          error_count++;
        end else begin
          compare_field("lsu_we", next_acc, 64'(lsu_we_i), e_we[next_acc]);
          compare_field("lsu_addr", next_acc, lsu_addr_i, e_addr[next_acc]);
          if (e_we[next_acc] != 0) begin
            compare_field("lsu_wdata", next_acc, lsu_wdata_i, e_wdata[next_acc]);
          end
          next_acc++;
        end
      end
    end
  end

endmodule

/* tests/exu_tb.sv */
`timescale 1ns/1ps

module exu_tb;
  import exu_pkg::*;

  localparam int max_lines = 64;
  localparam int ncols     = 18;
  localparam logic [xlen-1:0] rdata_mask = 64'h5a5a_5a5a_5a5a_5a5a;

  logic            clk = 1'b0;
  logic            rst;
  logic            valid_i;
  logic            ready_o;
  op_class_e       class_i;
  alu_op_e         alu_op_i;
  csr_op_e         csr_op_i;
  logic [11:0]     csr_addr_i;
  logic [xlen-1:0] src1_i;
  logic [xlen-1:0] src2_i;
  logic [xlen-1:0] base_i;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] pc_i;
  logic [4:0]      rd_i;
  logic            rd_wen_i;
  logic            valid_o;
  logic            ready_i;
  logic [4:0]      wb_rd_o;
  logic            wb_wen_o;
  logic [xlen-1:0] wb_data_o;
  logic            redirect_o;
  logic [xlen-1:0] redirect_pc_o;
  logic            ebreak_o;
  logic            lsu_req_o;
  logic            lsu_we_o;
  logic [xlen-1:0] lsu_addr_o;
  logic [xlen-1:0] lsu_wdata_o;
  logic            lsu_ack_i;
  logic [xlen-1:0] lsu_rdata_i;

  // one row per instruction in stim file column order
  logic [xlen-1:0] stim [0:max_lines-1][0:ncols-1];
  int n_lines;
  int load_errors;
  int sent;
  int cur;
  int wait_cnt;
  int seed;
  bit loaded = 1'b0;
  int chk_errors;
  int retired;
  int pending_acc;

  always #10 clk = ~clk;

  exu_top exu_top_i (.*);

  exu_checker chk_i (
    .clk           (clk),
    .rst           (rst),
    .valid_i       (valid_o),
    .ready_i       (ready_i),
    .wb_rd_i       (wb_rd_o),
    .wb_wen_i      (wb_wen_o),
    .wb_data_i     (wb_data_o),
    .redirect_i    (redirect_o),
    .redirect_pc_i (redirect_pc_o),
    .ebreak_i      (ebreak_o),
    .lsu_req_i     (lsu_req_o),
    .lsu_ack_i     (lsu_ack_i),
    .lsu_we_i      (lsu_we_o),
    .lsu_addr_i    (lsu_addr_o),
    .lsu_wdata_i   (lsu_wdata_o),
    .errors_o      (chk_errors),
    .retired_o     (retired),
    .pending_acc_o (pending_acc)
  );

  task automatic load_stimulus();
    int fd;
    int cnt;
    string line;
    logic [xlen-1:0] col [0:ncols-1];
    fd = $fopen("tests/exu_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open stimulus file tests/exu_stim.txt");
      load_errors++;
      return;
    end
    while (!$feof(fd)) begin
      cnt = $fgets(line, fd);
      if (cnt > 0 && line[0] != "#") begin
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                      col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                      col[15], col[16], col[17]);
        if (cnt == ncols && n_lines < max_lines) begin
          for (int j = 0; j < ncols; j++) begin
            stim[n_lines][j] = col[j];
          end
          chk_i.expect_result(col[11], col[12], col[9], col[13], col[14], col[15]);
          if (col[0] == 64'(cls_load) || col[0] == 64'(cls_store)) begin
            chk_i.expect_access({63'd0, col[0] == 64'(cls_store)}, col[16], col[17]);
          end
          n_lines++;
        end else if (cnt > 0) begin
          $display("malformed or extra stimulus line: %s", line);
          load_errors++;
        end
      end
    end
    $fclose(fd);
  endtask

  task apply_line(input int idx);
    class_i    = op_class_e'(stim[idx][0][3:0]);
    alu_op_i   = alu_op_e'(stim[idx][1][3:0]);
    csr_op_i   = csr_op_e'(stim[idx][2][1:0]);
    csr_addr_i = stim[idx][3][11:0];
    src1_i     = stim[idx][4];
    src2_i     = stim[idx][5];
    base_i     = stim[idx][6];
    imm_i      = stim[idx][7];
    pc_i       = stim[idx][8];
    rd_i       = stim[idx][9][4:0];
    rd_wen_i   = stim[idx][10][0];
  endtask

  // hold the current line until it is taken, then maybe leave a gap
  task feed_stimulus();
    if (sent >= n_lines) begin
      valid_i = 1'b0;
    end else if (!valid_i || cur != sent) begin
      if (($random(seed) & 3) == 0) begin
        valid_i = 1'b0;
      end else begin
        apply_line(sent);
        cur     = sent;
        valid_i = 1'b1;
      end
    end
  endtask

  // memory model acks 0 to 3 cycles after the request
  task respond_memory();
    lsu_ack_i = 1'b0;
    if (lsu_req_o) begin
      if (wait_cnt < 0) begin
        wait_cnt = $random(seed) & 3;
      end
      if (wait_cnt == 0) begin
        lsu_ack_i   = 1'b1;
        lsu_rdata_i = lsu_addr_o ^ rdata_mask;
        wait_cnt    = -1;
      end else begin
        wait_cnt--;
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      sent <= 0;
    end else if (valid_i && ready_o) begin
      sent <= sent + 1;
    end
  end

  // all inputs change on the falling edge
  initial begin
    seed        = 32'hf624;
    cur         = -1;
    wait_cnt    = -1;
    valid_i     = 1'b0;
    class_i     = cls_alu;
    alu_op_i    = alu_add;
    csr_op_i    = csr_rw;
    csr_addr_i  = '0;
    src1_i      = '0;
    src2_i      = '0;
    base_i      = '0;
    imm_i       = '0;
    pc_i        = '0;
    rd_i        = '0;
    rd_wen_i    = 1'b0;
    ready_i     = 1'b0;
    lsu_ack_i   = 1'b0;
    lsu_rdata_i = '0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        ready_i = ($random(seed) & 3) != 0;
        respond_memory();
        feed_stimulus();
      end
    end
  end

  initial begin
    int total;
    rst         = 1'b1;
    n_lines     = 0;
    load_errors = 0;
    load_stimulus();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (retired < n_lines) @(posedge clk);
    repeat (5) @(posedge clk);
    total = chk_errors + load_errors + pending_acc;
    if (n_lines == 0) begin
      $display("no instructions were loaded");
      total++;
    end
    $display("errors %0d (checker %0d, load %0d, accesses left %0d), retired %0d of %0d",
             total, chk_errors, load_errors, pending_acc, retired, n_lines);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // 40 cycles per instruction plus reset
  initial begin
    wait (loaded);
    repeat (n_lines * 40 + 20) @(posedge clk);
    $display("timeout: only %0d of %0d instructions retired", retired, n_lines);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* tests/exu_stim.txt */
# class alu_op csr_op csr_addr src1 src2 base imm pc rd rd_wen (all hex)
# then expected: wb_data wb_wen redirect redirect_pc ebreak lsu_addr lsu_wdata
0 0 0 000 5 3 0 0 1000 1 1 8 1 0 0 0 0 0
0 1 0 000 5 7 0 0 1004 2 1 fffffffffffffffe 1 0 0 0 0 0
0 2 0 000 f0f0 ff00 0 0 1008 3 1 f000 1 0 0 0 0 0
0 3 0 000 f0f0 0f0f 0 0 100c 4 1 ffff 1 0 0 0 0 0
0 4 0 000 ff 0f 0 0 1010 5 1 f0 1 0 0 0 0 0
0 5 0 000 1 44 0 0 1014 6 1 10 1 0 0 0 0 0
0 6 0 000 8000000000000000 4 0 0 1018 7 1 0800000000000000 1 0 0 0 0 0
0 7 0 000 8000000000000000 4 0 0 101c 8 1 f800000000000000 1 0 0 0 0 0
0 8 0 000 ffffffffffffffff 1 0 0 1020 9 1 1 1 0 0 0 0 0
0 9 0 000 ffffffffffffffff 1 0 0 1024 a 1 0 1 0 0 0 0 0
0 a 0 000 ffffffffffffffff 1 0 0 1028 b 1 0 1 0 0 0 0 0
0 b 0 000 ffffffffffffffff 1 0 0 102c c 1 1 1 0 0 0 0 0
0 0 0 000 1 1 0 0 1030 0 0 0 0 0 0 0 0 0
3 1 0 000 4 4 2000 10 2000 0 0 0 0 1 2010 0 0 0
3 4 0 000 4 4 2000 10 2004 0 0 0 0 0 0 0 0 0
3 4 0 000 4 5 2000 10 2008 0 0 0 0 1 2010 0 0 0
3 8 0 000 ffffffffffffffff 1 2000 10 200c 0 0 0 0 1 2010 0 0 0
3 9 0 000 ffffffffffffffff 1 2000 10 2010 0 0 0 0 0 0 0 0 0
3 a 0 000 1 ffffffffffffffff 2000 10 2014 0 0 0 0 1 2010 0 0 0
3 b 0 000 1 ffffffffffffffff 2000 10 2018 0 0 0 0 0 0 0 0 0
4 0 0 000 0 0 3000 100 3000 1 1 3004 1 1 3100 0 0 0
5 0 0 000 0 0 4000 8 3100 1 1 3104 1 1 4008 0 0 0
2 0 0 000 0 1234567812345678 8000 8 3104 0 0 0 0 0 0 0 8008 1234567812345678
1 0 0 000 0 0 8000 10 3108 3 1 5a5a5a5a5a5ada4a 1 0 0 0 8010 0
1 0 0 000 0 0 0 100 310c 4 1 5a5a5a5a5a5a5b5a 1 0 0 0 100 0
2 0 0 000 0 55 8000 20 3110 0 0 0 0 0 0 0 8020 55
6 0 0 305 9000 0 0 0 3200 5 1 0 1 0 0 0 0 0
6 0 1 305 f 0 0 0 3204 6 1 9000 1 0 0 0 0 0
6 0 2 305 f 0 0 0 3208 7 1 900f 1 0 0 0 0 0
7 0 0 000 0 0 0 0 5000 0 0 0 0 1 9000 0 0 0
6 0 1 341 0 0 0 0 9000 8 1 5000 1 0 0 0 0 0
6 0 1 342 0 0 0 0 9004 9 1 b 1 0 0 0 0 0
6 0 0 300 80 0 0 0 9008 a 1 0 1 0 0 0 0 0
8 0 0 000 0 0 0 0 900c b 1 80 1 1 5000 0 0 0
6 0 1 300 0 0 0 0 5000 c 1 88 1 0 0 0 0 0
9 0 0 000 0 0 0 0 6000 0 0 0 0 1 6000 1 0 0
0 0 0 000 2 2 0 0 6004 d 1 4 1 0 0 0 0 0

/* flist.f */
verilog/exu_pkg.sv
verilog/exu_alu.sv
verilog/exu_csr_file.sv
verilog/exu_stage.sv
verilog/exu_mem_stage.sv
verilog/exu_top.sv
tests/exu_sva.sv
tests/exu_checker.sv
tests/exu_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module exu_tb -f flist.f -o exu_sim &&
  ./obj_dir/exu_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
  echo "run.sh: simulation passed" ||
  { echo "run.sh: build or simulation failed"; exit 1; }
